// ==== design/data_mem.sv ====
// Sixteen-byte data memory, asynchronous read and clocked write
`timescale 1ns/10ps
`default_nettype none

module data_mem
    import rns_core_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic [MEM_ADDR_W-1:0] addr,      // Execute register address
    output word_t                      dout,
    input  wire logic                  wr_en,
    input  wire logic [MEM_ADDR_W-1:0] wr_addr,
    input  wire word_t                 wr_data
);

    word_t mem [2**MEM_ADDR_W];

    assign dout = mem[addr];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // Once reset has settled the enable it stays known
    assert property (@(posedge clk) !$isunknown(wr_en) |=> !$isunknown(wr_en));
    assert property (@(posedge clk) wr_en |-> !$isunknown(wr_data));

endmodule

`default_nettype wire

// ==== design/instr_decode.sv ====
// Instruction field split, register file read addressing and the ID/EX pipeline register
`timescale 1ns/10ps
`default_nettype none

module instr_decode
    import rns_core_pkg::*;
#(
    parameter int NUM_DOMAINS = 3
)(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic [15:0]              instr,
    input  wire logic                     flush,        // Kill this instruction downstream
    input  wire word_t                    scalar_rd_a,
    input  wire word_t                    scalar_rd_b,
    input  wire logic [NUM_DOMAINS*8-1:0] rns_rd_a,
    input  wire logic [NUM_DOMAINS*8-1:0] rns_rd_b,
    output logic [2:0]                    rd_addr_a,    // rs1 to both files
    output logic [2:0]                    rd_addr_b,    // rs2 to both files
    output opcode_e                       opcode,
    output logic [2:0]                    rd,
    output word_t                         a,
    output word_t                         b,
    output logic [NUM_DOMAINS*8-1:0]      ra,
    output logic [NUM_DOMAINS*8-1:0]      rb,
    output logic [1:0]                    lane,
    output word_t                         imm,
    output logic                          invalidate_fetch
);

    assign rd_addr_a = instr[RS1_HI:RS1_LO];
    assign rd_addr_b = instr[RS2_HI:RS2_LO];

    // Control part of ID/EX, NOP after reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            opcode           <= OP_NOP;
            invalidate_fetch <= 1'b0;
        end
        else
        begin
            opcode           <= opcode_e'(instr[OPC_HI:OPC_LO]);
            invalidate_fetch <= flush;  // Flush travels with its instruction
        end
    end

    // Operands and fields
    always_ff @(posedge clk)
    begin
        rd   <= instr[RD_HI:RD_LO];
        a    <= scalar_rd_a;
        b    <= scalar_rd_b;
        ra   <= rns_rd_a;
        rb   <= rns_rd_b;
        lane <= instr[LANE_HI:LANE_LO];
        imm  <= instr[IMM_HI:IMM_LO];
    end

    // An RGET in execute must name an existing lane
    assert property (@(posedge clk) disable iff (reset)
        (opcode == OP_RGET) |-> (lane < NUM_DOMAINS));

endmodule

`default_nettype wire

// ==== design/lane_execute.sv ====
// Scalar ALU, modular RNS lane arithmetic, predicate check and the EX/MEM pipeline register
`timescale 1ns/10ps
`default_nettype none

module lane_execute
    import rns_core_pkg::*;
#(
    parameter int NUM_DOMAINS = 3
)(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire opcode_e                  opcode,
    input  wire logic [2:0]               rd,
    input  wire word_t                    a,
    input  wire word_t                    b,
    input  wire logic [NUM_DOMAINS*8-1:0] ra,
    input  wire logic [NUM_DOMAINS*8-1:0] rb,
    input  wire logic [1:0]               lane,
    input  wire word_t                    imm,
    input  wire logic                     invalidate_fetch,
    input  wire word_t                    io_in,
    input  wire logic [3:0]               flags,         // Held flags from writeback
    output logic [NUM_DOMAINS*8-1:0]      operation_result,
    output word_t                         store_data,
    output logic [MEM_ADDR_W-1:0]         mem_addr,
    output logic [2:0]                    wb_rd,
    output logic                          store_to_mem,
    output logic                          reg_wr,
    output logic                          save_cout,
    output logic                          invalidate_execute,
    output logic                          load,
    output logic                          wb_invalidate_fetch,
    output logic                          destination_rns,
    output logic                          out_op,
    output logic                          in_op,
    output logic [4:0]                    branch_conds   // {cmp, carry, gt, lt, eq}
);

    localparam int W = NUM_DOMAINS*8;

    word_t       scalar_res;
    logic        carry;      // ADD carry out, zero otherwise
    wire  [W-1:0] lane_res;   // All lanes for RADD, RSUB, RSET
    logic        is_rns_op;

    assign is_rns_op = opcode inside {OP_RADD, OP_RSUB, OP_RSET};

    always_comb
    begin
        carry = 1'b0;
        case (opcode)
            OP_ADD:  {carry, scalar_res} = {1'b0, a} + {1'b0, b};
            OP_SUB:  scalar_res = a - b;
            OP_AND:  scalar_res = a & b;
            OP_LDI:  scalar_res = imm;
            OP_RGET: scalar_res = ra[lane*8 +: 8];
            OP_IN:   scalar_res = io_in;
            default: scalar_res = a;   // MOVEQ, MOVC, OUT
        endcase
    end

    genvar i;
    generate
        for (i = 0; i < NUM_DOMAINS; i++)
        begin : g_lane
            logic [7:0] x;
            logic [7:0] y;
            logic [7:0] m;
            logic [8:0] sum;
            logic [8:0] diff;  // Bit 8 is the borrow

            assign x    = ra[8*i +: 8];
            assign y    = rb[8*i +: 8];
            assign m    = MODULI[i];
            assign sum  = {1'b0, x} + {1'b0, y};
            assign diff = {1'b0, x} - {1'b0, y};

            // Operands below m, so one correction is enough
            assign lane_res[8*i +: 8] =
                (opcode == OP_RADD) ? ((sum >= m) ? 8'(sum - m) : sum[7:0]) :
                (opcode == OP_RSUB) ? (diff[8] ? 8'(diff + m) : diff[7:0]) :
                ((a >= m) ? (a - m) : a);   // RSET, every modulus above 128

            // Residues written back stay below their modulus
            assert property (@(posedge clk) disable iff (reset)
                destination_rns |-> (operation_result[8*i +: 8] < m));
        end
    endgenerate

    // Control bits, cleared by reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            store_to_mem        <= 1'b0;
            reg_wr              <= 1'b0;
            save_cout           <= 1'b0;
            invalidate_execute  <= 1'b0;
            load                <= 1'b0;
            wb_invalidate_fetch <= 1'b0;
            destination_rns     <= 1'b0;
            out_op              <= 1'b0;
            in_op               <= 1'b0;
            branch_conds        <= '0;
        end
        else
        begin
            store_to_mem        <= (opcode == OP_ST);
            reg_wr              <= !(opcode inside {OP_NOP, OP_ST, OP_CMP, OP_OUT});
            save_cout           <= opcode inside {OP_ADD, OP_SUB};  // SUB clears carry
            invalidate_execute  <= ((opcode == OP_MOVEQ) && !flags[FLAG_EQ]) ||
                                   ((opcode == OP_MOVC) && !flags[FLAG_CARRY]);
            load                <= (opcode == OP_LD);
            wb_invalidate_fetch <= invalidate_fetch;
            destination_rns     <= is_rns_op;
            out_op              <= (opcode == OP_OUT);
            in_op               <= (opcode == OP_IN);
            branch_conds[FLAG_EQ]    <= (a == b);
            branch_conds[FLAG_LT]    <= (a < b);   // Unsigned
            branch_conds[FLAG_GT]    <= (a > b);
            branch_conds[FLAG_CARRY] <= carry;
            branch_conds[COND_CMP]   <= (opcode == OP_CMP);
        end
    end

    // Payload
    always_ff @(posedge clk)
    begin
        operation_result <= is_rns_op ? lane_res : W'(scalar_res);  // Scalar in low byte
        store_data       <= b;
        mem_addr         <= a[MEM_ADDR_W-1:0];  // LD/ST address from rs1
        wb_rd            <= rd;
    end

endmodule

`default_nettype wire

// ==== design/mem_writeback.sv ====
// Load select, invalidate gating of enables and I/O strobes, held flags register
`timescale 1ns/10ps
`default_nettype none

module mem_writeback
    import rns_core_pkg::*;
#(
    parameter int NUM_DOMAINS = 3
)(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic [NUM_DOMAINS*8-1:0] operation_result,  // Lane 0 in low byte
    input  wire word_t                    store_data,
    input  wire logic [MEM_ADDR_W-1:0]    mem_addr,
    input  wire logic [2:0]               wb_rd,
    input  wire logic                     store_to_mem,
    input  wire logic                     reg_wr,
    input  wire logic                     save_cout,
    input  wire logic                     invalidate_execute,  // Failed predicate
    input  wire logic                     load,
    input  wire logic                     invalidate_fetch,    // Flushed at issue
    input  wire logic                     destination_rns,
    input  wire logic                     out_op,
    input  wire logic                     in_op,
    input  wire logic [4:0]               branch_conds,
    input  wire word_t                    dmem_dout,
    output logic                          scalar_wr_en,
    output logic                          rns_wr_en,
    output logic [2:0]                    wr_addr,
    output logic [NUM_DOMAINS*8-1:0]      wr_data,
    output logic                          mem_wr_en,
    output logic [MEM_ADDR_W-1:0]         mem_wr_addr,
    output word_t                         mem_wr_data,
    output word_t                         io_write_data,
    output logic                          io_write_strobe,
    output logic                          io_read_strobe,
    output logic [3:0]                    flags
);

    localparam int W = NUM_DOMAINS*8;

    logic invalidate;

    assign invalidate = invalidate_fetch || invalidate_execute;

    assign wr_data      = load ? W'(dmem_dout) : operation_result;  // Load zero-extended
    assign wr_addr      = wb_rd;
    assign scalar_wr_en = reg_wr && !destination_rns && !invalidate;
    assign rns_wr_en    = reg_wr && destination_rns && !invalidate;

    assign mem_wr_en    = store_to_mem && !invalidate;
    assign mem_wr_addr  = mem_addr;
    assign mem_wr_data  = store_data;

    assign io_write_data   = operation_result[7:0];  // OUT data is rs1 in low byte
    assign io_write_strobe = out_op && !invalidate;
    assign io_read_strobe  = in_op && !invalidate;   // io_in already taken in execute

    // Flags hold until a valid update
    always_ff @(posedge clk)
    begin
        if (reset)
            flags <= '0;
        else
        begin
            if (save_cout && !invalidate)
                flags[FLAG_CARRY] <= branch_conds[FLAG_CARRY];
            if (branch_conds[COND_CMP] && !invalidate)
                flags[FLAG_GT:FLAG_EQ] <= branch_conds[FLAG_GT:FLAG_EQ];
        end
    end

    // OUT and IN never share the execute register
    assert property (@(posedge clk) disable iff (reset)
        !(io_write_strobe && io_read_strobe));

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
// Eight-entry register file with two combinational reads and one clocked write
`timescale 1ns/10ps
`default_nettype none

module reg_file #(
    parameter type word_t = logic [7:0]   // Scalar byte or RNS lane vector
)(
    input  wire logic       clk,
    input  wire logic [2:0] rd_addr_a,
    input  wire logic [2:0] rd_addr_b,
    output word_t           rd_data_a,
    output word_t           rd_data_b,
    input  wire logic       wr_en,
    input  wire logic [2:0] wr_addr,
    input  wire word_t      wr_data
);

    word_t regs [8];

    // No write-through, readers rely on issue spacing
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            regs[wr_addr] <= wr_data;
    end

    // Writeback only ever delivers known data
    assert property (@(posedge clk) wr_en |-> !$isunknown(wr_data));

endmodule

`default_nettype wire

// ==== design/rns_core_pkg.sv ====
// Opcodes, instruction field positions, flag indices, RNS moduli and the scalar word type
`default_nettype none

package rns_core_pkg;

    typedef logic [7:0] word_t;  // Scalar register and memory word

    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_ADD   = 4'd1,
        OP_SUB   = 4'd2,
        OP_AND   = 4'd3,
        OP_LDI   = 4'd4,
        OP_LD    = 4'd5,
        OP_ST    = 4'd6,
        OP_CMP   = 4'd7,
        OP_MOVEQ = 4'd8,   // Move if EQ flag set
        OP_MOVC  = 4'd9,   // Move if carry flag set
        OP_RADD  = 4'd10,
        OP_RSUB  = 4'd11,
        OP_RSET  = 4'd12,  // Scalar into every lane
        OP_RGET  = 4'd13,  // One lane back to scalar
        OP_OUT   = 4'd14,
        OP_IN    = 4'd15
    } opcode_e;

    // Instruction fields
    localparam int OPC_HI  = 15;
    localparam int OPC_LO  = 12;
    localparam int RD_HI   = 11;
    localparam int RD_LO   = 9;
    localparam int RS1_HI  = 8;
    localparam int RS1_LO  = 6;
    localparam int RS2_HI  = 5;
    localparam int RS2_LO  = 3;
    localparam int LANE_HI = 1;
    localparam int LANE_LO = 0;
    localparam int IMM_HI  = 7;   // LDI only, overlaps rs1/rs2
    localparam int IMM_LO  = 0;

    // Positions in flags and branch_conds
    localparam int FLAG_EQ    = 0;
    localparam int FLAG_LT    = 1;
    localparam int FLAG_GT    = 2;
    localparam int FLAG_CARRY = 3;
    localparam int COND_CMP   = 4;  // compare_true, branch_conds only

    localparam int MAX_DOMAINS = 4;
    // Lane i uses entry i
    localparam logic [MAX_DOMAINS-1:0][7:0] MODULI = {8'd233, 8'd239, 8'd241, 8'd251};

    localparam int MEM_ADDR_W = 4;  // Sixteen bytes of data memory

endpackage

`default_nettype wire

// ==== design/rns_core_top.sv ====
// Three-stage RNS core: decode, execute, memory/writeback, register files and data memory
`timescale 1ns/10ps
`default_nettype none

module rns_core_top
    import rns_core_pkg::*;
#(
    parameter int NUM_DOMAINS = 3
)(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [15:0] instr,
    input  wire logic        flush,
    input  wire word_t       io_in,
    output word_t            io_write_data,
    output logic             io_write_strobe,
    output logic             io_read_strobe,
    output logic [3:0]       flags
);

    typedef logic [NUM_DOMAINS*8-1:0] lanes_t;  // Lane 0 in low byte

    logic [2:0]            rd_addr_a;
    logic [2:0]            rd_addr_b;
    word_t                 scalar_rd_a;
    word_t                 scalar_rd_b;
    lanes_t                rns_rd_a;
    lanes_t                rns_rd_b;

    // ID/EX
    opcode_e               id_opcode;
    logic [2:0]            id_rd;
    word_t                 id_a;
    word_t                 id_b;
    lanes_t                id_ra;
    lanes_t                id_rb;
    logic [1:0]            id_lane;
    word_t                 id_imm;
    logic                  id_invalidate_fetch;

    // EX/MEM
    lanes_t                ex_result;
    word_t                 ex_store_data;
    logic [MEM_ADDR_W-1:0] ex_mem_addr;
    logic [2:0]            ex_rd;
    logic                  ex_store_to_mem;
    logic                  ex_reg_wr;
    logic                  ex_save_cout;
    logic                  ex_invalidate_execute;
    logic                  ex_load;
    logic                  ex_invalidate_fetch;
    logic                  ex_destination_rns;
    logic                  ex_out_op;
    logic                  ex_in_op;
    logic [4:0]            ex_branch_conds;

    // Writeback side
    word_t                 dmem_dout;
    logic                  scalar_wr_en;
    logic                  rns_wr_en;
    logic [2:0]            wr_addr;
    lanes_t                wr_data;
    logic                  mem_wr_en;
    logic [MEM_ADDR_W-1:0] mem_wr_addr;
    word_t                 mem_wr_data;

    instr_decode #(.NUM_DOMAINS(NUM_DOMAINS)) u_decode (
        .clk(clk), .reset(reset), .instr(instr), .flush(flush),
        .scalar_rd_a(scalar_rd_a), .scalar_rd_b(scalar_rd_b),
        .rns_rd_a(rns_rd_a), .rns_rd_b(rns_rd_b),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .opcode(id_opcode), .rd(id_rd), .a(id_a), .b(id_b),
        .ra(id_ra), .rb(id_rb), .lane(id_lane), .imm(id_imm),
        .invalidate_fetch(id_invalidate_fetch)
    );

    lane_execute #(.NUM_DOMAINS(NUM_DOMAINS)) u_execute (
        .clk(clk), .reset(reset),
        .opcode(id_opcode), .rd(id_rd), .a(id_a), .b(id_b),
        .ra(id_ra), .rb(id_rb), .lane(id_lane), .imm(id_imm),
        .invalidate_fetch(id_invalidate_fetch), .io_in(io_in), .flags(flags),
        .operation_result(ex_result), .store_data(ex_store_data),
        .mem_addr(ex_mem_addr), .wb_rd(ex_rd),
        .store_to_mem(ex_store_to_mem), .reg_wr(ex_reg_wr), .save_cout(ex_save_cout),
        .invalidate_execute(ex_invalidate_execute), .load(ex_load),
        .wb_invalidate_fetch(ex_invalidate_fetch), .destination_rns(ex_destination_rns),
        .out_op(ex_out_op), .in_op(ex_in_op), .branch_conds(ex_branch_conds)
    );

    mem_writeback #(.NUM_DOMAINS(NUM_DOMAINS)) u_writeback (
        .clk(clk), .reset(reset),
        .operation_result(ex_result), .store_data(ex_store_data),
        .mem_addr(ex_mem_addr), .wb_rd(ex_rd),
        .store_to_mem(ex_store_to_mem), .reg_wr(ex_reg_wr), .save_cout(ex_save_cout),
        .invalidate_execute(ex_invalidate_execute), .load(ex_load),
        .invalidate_fetch(ex_invalidate_fetch), .destination_rns(ex_destination_rns),
        .out_op(ex_out_op), .in_op(ex_in_op), .branch_conds(ex_branch_conds),
        .dmem_dout(dmem_dout),
        .scalar_wr_en(scalar_wr_en), .rns_wr_en(rns_wr_en),
        .wr_addr(wr_addr), .wr_data(wr_data),
        .mem_wr_en(mem_wr_en), .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data),
        .io_write_data(io_write_data), .io_write_strobe(io_write_strobe),
        .io_read_strobe(io_read_strobe), .flags(flags)
    );

    data_mem u_dmem (
        .clk(clk), .addr(ex_mem_addr), .dout(dmem_dout),
        .wr_en(mem_wr_en), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data)
    );

    reg_file #(.word_t(word_t)) scalar_regs (
        .clk(clk), .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(scalar_rd_a), .rd_data_b(scalar_rd_b),
        .wr_en(scalar_wr_en), .wr_addr(wr_addr), .wr_data(wr_data[7:0])
    );

    reg_file #(.word_t(lanes_t)) rns_regs (
        .clk(clk), .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rns_rd_a), .rd_data_b(rns_rd_b),
        .wr_en(rns_wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

endmodule

`default_nettype wire

// ==== dv/rns_core_tb.sv ====
// RNS core testbench with clock, reset, seeded random programs, ISA model, checks and timeout
`timescale 1ns/10ps
`default_nettype none

module rns_core_tb
    import rns_core_pkg::*;
();

    localparam int ND             = 3;
    localparam int N_PRE          = 48;    // 8 LDI, 8 RSET, 16 x (LDI, ST)
    localparam int N_RAND         = 300;
    localparam int RESET_CYCLES   = 3;
    localparam int TIMEOUT_CYCLES = 3*(N_PRE + N_RAND) + RESET_CYCLES + 50;
    localparam logic [7:0] LANE_MOD [4] = '{8'd251, 8'd241, 8'd239, 8'd233};

    logic        clk;
    logic        reset;
    logic [15:0] instr;
    logic        flush;
    logic [7:0]  io_in;
    logic [7:0]  io_write_data;
    logic        io_write_strobe;
    logic        io_read_strobe;
    logic [3:0]  flags;

    integer      seed;
    logic [7:0]  io_next;         // Last value put on io_in
    int          cycles;

    // ISA model state
    logic [7:0]  m_reg [8];
    logic [7:0]  m_lane [8][ND];
    logic [7:0]  m_mem [16];
    logic [3:0]  m_flags;
    logic [7:0]  out_q [$];       // Pending OUT data
    logic [7:0]  in_q [$];        // Pending IN data

    rns_core_top #(.NUM_DOMAINS(ND)) DUT (
        .clk(clk), .reset(reset), .instr(instr), .flush(flush), .io_in(io_in),
        .io_write_data(io_write_data), .io_write_strobe(io_write_strobe),
        .io_read_strobe(io_read_strobe), .flags(flags)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
            abort_run("a checked value was wrong");
        end
    endtask

    // Hard stop in case the program never ends
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            abort_run($sformatf("timeout, program not finished after %0d cycles", cycles));
    end

    // Port monitor on strobes from the execute register
    always @(posedge clk)
    begin
        if (io_write_strobe === 1'b1)
        begin
            if (out_q.size() == 0)
                abort_run("io_write_strobe pulsed while no OUT was expected");
            else
                check("out_data", out_q.pop_front(), io_write_data);
        end
        if (io_read_strobe === 1'b1)
        begin
            if (in_q.size() == 0)
                abort_run("io_read_strobe pulsed while no IN was expected");
            else
                check("in_data", in_q.pop_front(), DUT.wr_data[7:0]);  // Sampled io_in
        end
        if (DUT.rns_wr_en === 1'b1)
            for (int i = 0; i < ND; i++)
                check("lane_range", 1, DUT.wr_data[8*i +: 8] < LANE_MOD[i]);
    end

    task automatic next_cycle(input logic [15:0] ins, input logic fl);
        @(posedge clk);
        io_next = 8'($random(seed));  // Fresh io_in every cycle
        instr <= ins;
        flush <= fl;
        io_in <= io_next;
    endtask

    // One ISA instruction applied when it sits in execute
    task automatic step_model(input logic [15:0] ins, input logic fl, input logic [7:0] in_val);
        logic [2:0] rd;
        logic [2:0] s1;
        logic [2:0] s2;
        logic [7:0] a;
        logic [7:0] b;
        logic [8:0] sum;
        int         x;
        int         y;
        int         m;
        rd  = ins[11:9];
        s1  = ins[8:6];
        s2  = ins[5:3];
        a   = m_reg[s1];
        b   = m_reg[s2];
        sum = a + b;
        if (!fl)                      // Flushed means no effect at all
        begin
            case (ins[15:12])
                OP_ADD:
                begin
                    m_reg[rd]           = sum[7:0];
                    m_flags[FLAG_CARRY] = sum[8];
                end
                OP_SUB:
                begin
                    m_reg[rd]           = a - b;
                    m_flags[FLAG_CARRY] = 1'b0;
                end
                OP_AND:  m_reg[rd] = a & b;
                OP_LDI:  m_reg[rd] = ins[7:0];
                OP_LD:   m_reg[rd] = m_mem[a[3:0]];
                OP_ST:   m_mem[a[3:0]] = b;
                OP_CMP:
                begin
                    m_flags[FLAG_EQ] = (a == b);
                    m_flags[FLAG_LT] = (a < b);
                    m_flags[FLAG_GT] = (a > b);
                end
                OP_MOVEQ: if (m_flags[FLAG_EQ]) m_reg[rd] = a;
                OP_MOVC:  if (m_flags[FLAG_CARRY]) m_reg[rd] = a;
                OP_RADD, OP_RSUB, OP_RSET:
                    for (int i = 0; i < ND; i++)
                    begin
                        x = m_lane[s1][i];
                        y = m_lane[s2][i];
                        m = LANE_MOD[i];
                        if (ins[15:12] == OP_RADD)
                            m_lane[rd][i] = (x + y) % m;
                        else if (ins[15:12] == OP_RSUB)
                            m_lane[rd][i] = (x - y + m) % m;
                        else
                            m_lane[rd][i] = int'(a) % m;  // Same scalar in every lane
                    end
                OP_RGET: m_reg[rd] = m_lane[s1][ins[1:0]];
                OP_OUT:  out_q.push_back(a);
                OP_IN:
                begin
                    m_reg[rd] = in_val;
                    in_q.push_back(in_val);
                end
                default: ;            // NOP
            endcase
        end
    endtask

    // Issue plus two NOPs keeps the pipeline free of hazards
    task automatic run_instr(input logic [15:0] ins, input logic fl);
        logic [7:0] in_val;
        next_cycle(ins, fl);
        next_cycle(16'h0000, 1'b0);
        check("flags", m_flags, flags);       // Update of the previous instruction
        in_val = io_next;                     // Taken as ins enters execute
        next_cycle(16'h0000, 1'b0);
        step_model(ins, fl, in_val);
    endtask

    initial
    begin
        logic [15:0] ins;
        logic        fl;
        seed        = 32'he9f5;
        clk         = 1'b0;
        reset       = 1'b1;
        instr       = 16'h0000;
        flush       = 1'b0;
        io_in       = 8'h00;
        io_next     = 8'h00;
        cycles      = 0;
        m_flags     = 4'h0;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int c = 0; c < 3; c++)           // Two reset cycles and the first free one
        begin
            check("reset_write_strobe", 0, io_write_strobe);
            check("reset_read_strobe", 0, io_read_strobe);
            check("reset_flags", 0, flags);
            next_cycle(16'h0000, 1'b0);
        end

        // Preamble gives every register, lane and byte a known value
        for (int r = 0; r < 8; r++)
            run_instr({OP_LDI, 3'(r), 1'b0, 8'($random(seed))}, 1'b0);
        for (int r = 0; r < 8; r++)
            run_instr({OP_RSET, 3'(r), 3'($random(seed)), 6'd0}, 1'b0);
        for (int addr = 0; addr < 16; addr++)
        begin
            run_instr({OP_LDI, 3'd0, 1'b0, 8'(addr)}, 1'b0);
            run_instr({OP_ST, 3'd0, 3'd0, 3'($random(seed)), 3'd0}, 1'b0);
        end

        for (int n = 0; n < N_RAND; n++)
        begin
            ins = 16'($random(seed));
            if (($random(seed) & 3) == 0)
                ins[15:12] = OP_OUT;          // More observation points
            if (ins[15:12] == OP_RGET)
                ins[1:0] = 2'($unsigned($random(seed)) % ND);  // Existing lane only
            fl = (($random(seed) & 7) == 0);  // One in eight flushed
            run_instr(ins, fl);
        end

        next_cycle(16'h0000, 1'b0);
        next_cycle(16'h0000, 1'b0);
        check("flags", m_flags, flags);
        check("out_left", 0, out_q.size());
        check("in_left", 0, in_q.size());
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
design/rns_core_pkg.sv
design/reg_file.sv
design/data_mem.sv
design/instr_decode.sv
design/lane_execute.sv
design/mem_writeback.sv
design/rns_core_top.sv
dv/rns_core_tb.sv
